//--- common/rv32i_isa_pkg.sv
//####################################################################
// rv32i isa definitions
// major opcodes, funct codes and instruction field layout
//####################################################################
package rv32i_isa_pkg;

    localparam int XLEN = 32; // word width

    typedef logic [4:0] reg_idx_t; // x0..x31
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // r-type field layout
    typedef struct packed {
        funct7_t  funct7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        funct3_t  funct3; // same spot in every format
        reg_idx_t rd;
        opcode_t  opcode;
    } instr_fields_t;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000; // sub / sra

endpackage

//--- common/uop_types_pkg.sv
//####################################################################
// micro-op types
// uop, fetch bundle and writeback records, alu operation codes
//####################################################################
package uop_types_pkg;

    localparam int FETCH_LANES = 2; // instruction words per fetch bundle

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    // all zero is a nop
    typedef struct packed {
        logic                           valid;
        logic [rv32i_isa_pkg::XLEN-1:0] pc;
        alu_op_t                        alu_op;
        rv32i_isa_pkg::reg_idx_t        rs1;
        rv32i_isa_pkg::reg_idx_t        rs2;
        rv32i_isa_pkg::reg_idx_t        rd;
        logic                           rd_we;
        logic                           use_imm; // operand b from imm
        logic                           is_branch;
        logic                           is_jump;
        logic                           is_load;
        logic                           is_store;
        logic                           illegal;
        logic [rv32i_isa_pkg::XLEN-1:0] imm;
    } uop_t;

    typedef struct packed {
        logic [rv32i_isa_pkg::XLEN-1:0]                  pc;         // lane 0 address
        logic [FETCH_LANES-1:0]                          lane_valid;
        logic [FETCH_LANES-1:0][rv32i_isa_pkg::XLEN-1:0] instr;
    } fetch_bundle_t;

    typedef struct packed {
        logic                    valid;
        rv32i_isa_pkg::reg_idx_t rd;
    } wb_t;

endpackage

//--- decode_queue/decode_queue.sv
//####################################################################
// decode queue
// shifting queue of decoded ops, head at slot 1, multi-entry store,
// stall, flush and free-slot count for the fetch side
//####################################################################
`timescale 1ns/1ps

module decode_queue #(
    parameter type D_TYPE        = logic [31:0],
    parameter int  QUEUE_LEN     = 8,
    parameter int  DISPATCH_SIZE = 2
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  D_TYPE [DISPATCH_SIZE-1:0]      ctrls,
    input  logic                           stall_queue,
    input  logic                           flush_queue,
    input  logic                           store,
    input  logic [$clog2(DISPATCH_SIZE):0] num_uops,
    output logic [$clog2(QUEUE_LEN)+1:0]   num_free_slots,
    output D_TYPE                          uop0
);

    typedef logic [$clog2(QUEUE_LEN)+1:0] idx_t;

    idx_t                  tail_idx;       // occupied entries
    idx_t                  nxt_tail_idx;
    idx_t                  base_idx;       // entries left after this cycle's shift
    D_TYPE [QUEUE_LEN:1]   queue_data;     // slot 0 unused
    D_TYPE [QUEUE_LEN:1]   nxt_queue_data;

    assign uop0 = queue_data[1]; // head

    // one entry leaves per unstalled cycle
    assign base_idx = (stall_queue || tail_idx == '0) ? tail_idx : tail_idx - 1'b1;

    // includes the slot freed by this cycle's shift
    assign num_free_slots = idx_t'(QUEUE_LEN) - base_idx;

    always_comb begin
        nxt_queue_data = queue_data; // hold by default

        if (!stall_queue) begin
            for (int i = 1; i < QUEUE_LEN; i++) begin
                nxt_queue_data[i] = queue_data[i+1];
            end
            nxt_queue_data[QUEUE_LEN] = '0; // nop in at the tail
        end

        if (store) begin
            for (int k = 0; k < DISPATCH_SIZE; k++) begin
                if (k < num_uops && base_idx + k < QUEUE_LEN) begin
                    nxt_queue_data[base_idx + k + 1] = ctrls[k]; // append behind tail
                end
            end
        end

        if (flush_queue) begin
            nxt_queue_data = '0; // flush wins over store
        end
    end

    always_comb begin
        nxt_tail_idx = base_idx;
        if (store) begin
            nxt_tail_idx = base_idx + num_uops;
        end
        if (flush_queue) begin
            nxt_tail_idx = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tail_idx   <= '0;
            queue_data <= '0; // valid bits live in the entries
        end else begin
            tail_idx   <= nxt_tail_idx;
            queue_data <= nxt_queue_data;
        end
    end

endmodule

//--- decoder/uop_decoder.sv
//####################################################################
// uop decoder
// decodes one rv32i instruction word into a micro-op
//####################################################################
`timescale 1ns/1ps

module uop_decoder (
    input  logic [rv32i_isa_pkg::XLEN-1:0] instr,
    input  logic [rv32i_isa_pkg::XLEN-1:0] pc,
    input  logic                           lane_valid,
    output uop_types_pkg::uop_t            uop
);

    rv32i_isa_pkg::instr_fields_t   f;
    logic [rv32i_isa_pkg::XLEN-1:0] imm_i;
    logic [rv32i_isa_pkg::XLEN-1:0] imm_s;
    logic [rv32i_isa_pkg::XLEN-1:0] imm_b;
    logic [rv32i_isa_pkg::XLEN-1:0] imm_u;
    logic [rv32i_isa_pkg::XLEN-1:0] imm_j;
    uop_types_pkg::alu_op_t         arith_op; // op / op_imm result
    logic                           alt;      // funct7 selects sub / sra

    assign f = instr;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign alt = (f.funct7 == rv32i_isa_pkg::F7_ALT);

    always_comb begin
        case (f.funct3)
            rv32i_isa_pkg::F3_ADD_SUB: begin
                // no subi, only the register form subtracts
                arith_op = (alt && f.opcode == rv32i_isa_pkg::OP) ? uop_types_pkg::SUB
                                                                   : uop_types_pkg::ADD;
            end
            rv32i_isa_pkg::F3_SLL:     arith_op = uop_types_pkg::SLL;
            rv32i_isa_pkg::F3_SLT:     arith_op = uop_types_pkg::SLT;
            rv32i_isa_pkg::F3_SLTU:    arith_op = uop_types_pkg::SLTU;
            rv32i_isa_pkg::F3_XOR:     arith_op = uop_types_pkg::XOR;
            rv32i_isa_pkg::F3_SRL_SRA: arith_op = alt ? uop_types_pkg::SRA : uop_types_pkg::SRL;
            rv32i_isa_pkg::F3_OR:      arith_op = uop_types_pkg::OR;
            default:                   arith_op = uop_types_pkg::AND;
        endcase
    end

    always_comb begin
        uop        = '0;
        uop.valid  = 1'b1;
        uop.pc     = pc;
        uop.alu_op = uop_types_pkg::ADD; // address / link add
        case (f.opcode)
            rv32i_isa_pkg::LUI, rv32i_isa_pkg::AUIPC: begin
                uop.rd_we   = 1'b1;
                uop.use_imm = 1'b1;
                uop.imm     = imm_u;
            end
            rv32i_isa_pkg::JAL: begin
                uop.rd_we   = 1'b1;
                uop.use_imm = 1'b1;
                uop.is_jump = 1'b1;
                uop.imm     = imm_j;
            end
            rv32i_isa_pkg::JALR: begin
                uop.rd_we   = 1'b1;
                uop.use_imm = 1'b1;
                uop.is_jump = 1'b1;
                uop.rs1     = f.rs1;
                uop.imm     = imm_i;
            end
            rv32i_isa_pkg::BRANCH: begin
                uop.alu_op    = uop_types_pkg::SUB; // compare
                uop.is_branch = 1'b1;
                uop.rs1       = f.rs1;
                uop.rs2       = f.rs2;
                uop.imm       = imm_b;
            end
            rv32i_isa_pkg::LOAD: begin
                uop.rd_we   = 1'b1;
                uop.use_imm = 1'b1;
                uop.is_load = 1'b1;
                uop.rs1     = f.rs1;
                uop.imm     = imm_i;
            end
            rv32i_isa_pkg::STORE: begin
                uop.use_imm  = 1'b1;
                uop.is_store = 1'b1;
                uop.rs1      = f.rs1;
                uop.rs2      = f.rs2; // store data
                uop.imm      = imm_s;
            end
            rv32i_isa_pkg::OP_IMM: begin
                uop.alu_op  = arith_op;
                uop.rd_we   = 1'b1;
                uop.use_imm = 1'b1;
                uop.rs1     = f.rs1;
                uop.imm     = imm_i;
            end
            rv32i_isa_pkg::OP: begin
                uop.alu_op = arith_op;
                uop.rd_we  = 1'b1;
                uop.rs1    = f.rs1;
                uop.rs2    = f.rs2;
            end
            default: uop.illegal = 1'b1; // no writes, no sources
        endcase

        if (uop.rd_we) begin
            uop.rd = f.rd; // unused rd stays x0
        end
        if (!lane_valid) begin
            uop = '0; // empty lane -> nop
        end
    end

endmodule

//--- decoder/fetch_bundle_decode.sv
//####################################################################
// fetch bundle decode
// per-lane decode, packs valid lanes to the front and accepts the
// bundle only when every op fits in the queue
//####################################################################
`timescale 1ns/1ps

module fetch_bundle_decode #(
    parameter int QUEUE_LEN     = 8,
    parameter int DISPATCH_SIZE = 2
) (
    input  logic                                    fetch_valid,
    input  uop_types_pkg::fetch_bundle_t            fetch_bundle,
    input  logic [$clog2(QUEUE_LEN)+1:0]            num_free_slots,
    output logic                                    fetch_ready,
    output uop_types_pkg::uop_t [DISPATCH_SIZE-1:0] ctrls,
    output logic [$clog2(DISPATCH_SIZE):0]          num_uops,
    output logic                                    store
);

    uop_types_pkg::uop_t [DISPATCH_SIZE-1:0]                 lane_uops; // unpacked lane order
    logic [DISPATCH_SIZE-1:0][rv32i_isa_pkg::XLEN-1:0]       lane_pc;

    for (genvar i = 0; i < DISPATCH_SIZE; i++) begin : g_lane
        assign lane_pc[i] = fetch_bundle.pc + 4 * i; // word per lane

        uop_decoder u_uop_decoder (
            .instr      (fetch_bundle.instr[i]),
            .pc         (lane_pc[i]),
            .lane_valid (fetch_bundle.lane_valid[i]),
            .uop        (lane_uops[i])
        );
    end

    // compact valid lanes, program order kept
    always_comb begin
        ctrls    = '0;
        num_uops = '0;
        for (int i = 0; i < DISPATCH_SIZE; i++) begin
            if (lane_uops[i].valid) begin
                ctrls[num_uops] = lane_uops[i];
                num_uops        = num_uops + 1'b1;
            end
        end
    end

    assign fetch_ready = (num_free_slots >= num_uops); // whole bundle or nothing
    assign store       = fetch_valid & fetch_ready;

endmodule

//--- design/issue_scoreboard.sv
//####################################################################
// issue scoreboard
// busy-register table, hazard check on the queue head and issue
// handshake with stall back to the queue
//####################################################################
`timescale 1ns/1ps

module issue_scoreboard (
    input  logic                CLK,
    input  logic                nRST,
    input  uop_types_pkg::uop_t head_uop,
    input  logic                issue_ready,
    input  uop_types_pkg::wb_t  wb,
    output logic                stall_queue,
    output logic                issue_valid,
    output uop_types_pkg::uop_t issue_uop
);

    logic [31:0] busy;       // one bit per architectural register
    logic [31:0] nxt_busy;
    logic        hazard;
    logic        issue_fire;

    // registered table only, wb this cycle not seen
    assign hazard = head_uop.valid
                  & (busy[head_uop.rs1] | busy[head_uop.rs2] | busy[head_uop.rd]);

    assign issue_valid = head_uop.valid & ~hazard;
    assign stall_queue = head_uop.valid & (~issue_ready | hazard); // keep head in slot 1
    assign issue_uop   = head_uop;
    assign issue_fire  = issue_valid & issue_ready;

    always_comb begin
        nxt_busy = busy;
        if (wb.valid) begin
            nxt_busy[wb.rd] = 1'b0;
        end
        if (issue_fire && head_uop.rd_we) begin
            nxt_busy[head_uop.rd] = 1'b1; // new writer wins over wb
        end
        nxt_busy[0] = 1'b0; // x0 never busy
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            busy <= nxt_busy;
        end
    end

endmodule

//--- design/decode_frontend.sv
//####################################################################
// decode front end
// fetch bundle decode, decode queue and issue scoreboard
//####################################################################
`timescale 1ns/1ps

module decode_frontend #(
    parameter int QUEUE_LEN     = 8,
    parameter int DISPATCH_SIZE = uop_types_pkg::FETCH_LANES
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         fetch_valid,
    input  uop_types_pkg::fetch_bundle_t fetch_bundle,
    output logic                         fetch_ready,
    input  logic                         redirect,
    input  logic                         issue_ready,
    output logic                         issue_valid,
    output uop_types_pkg::uop_t          issue_uop,
    input  uop_types_pkg::wb_t           wb
);

    uop_types_pkg::uop_t [DISPATCH_SIZE-1:0] ctrls;          // packed lanes
    logic [$clog2(DISPATCH_SIZE):0]          num_uops;
    logic                                    store;
    logic [$clog2(QUEUE_LEN)+1:0]            num_free_slots;
    uop_types_pkg::uop_t                     head_uop;       // queue slot 1
    logic                                    stall_queue;

    fetch_bundle_decode #(
        .QUEUE_LEN     (QUEUE_LEN),
        .DISPATCH_SIZE (DISPATCH_SIZE)
    ) u_fetch_bundle_decode (
        .fetch_valid    (fetch_valid),
        .fetch_bundle   (fetch_bundle),
        .num_free_slots (num_free_slots),
        .fetch_ready    (fetch_ready),
        .ctrls          (ctrls),
        .num_uops       (num_uops),
        .store          (store)
    );

    decode_queue #(
        .D_TYPE        (uop_types_pkg::uop_t),
        .QUEUE_LEN     (QUEUE_LEN),
        .DISPATCH_SIZE (DISPATCH_SIZE)
    ) u_decode_queue (
        .CLK            (CLK),
        .nRST           (nRST),
        .ctrls          (ctrls),
        .stall_queue    (stall_queue),
        .flush_queue    (redirect),       // busy table survives a redirect
        .store          (store),
        .num_uops       (num_uops),
        .num_free_slots (num_free_slots),
        .uop0           (head_uop)
    );

    issue_scoreboard u_issue_scoreboard (
        .CLK         (CLK),
        .nRST        (nRST),
        .head_uop    (head_uop),
        .issue_ready (issue_ready),
        .wb          (wb),
        .stall_queue (stall_queue),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

endmodule

//--- tests/decode_frontend_assert.sv
//####################################################################
// decode front end assertions
// issue handshake, hazard hold and reset checks, bound into the top
//####################################################################
`timescale 1ns/1ps

module decode_frontend_assert (
    input logic                CLK,
    input logic                nRST,
    input logic                fetch_ready,
    input logic                redirect,
    input logic                issue_valid,
    input logic                issue_ready,
    input logic                stall_queue,
    input uop_types_pkg::uop_t head_uop,
    input uop_types_pkg::uop_t issue_uop
);

    // head blocked by a hazard stays in slot 1
    a_hazard_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (stall_queue && !issue_valid && !redirect) |=> $stable(head_uop))
        else $error("queue head moved while held by a hazard");

    // empty queue right out of reset
    a_reset_state: assert property (@(posedge CLK)
        $rose(nRST) |-> (fetch_ready && !issue_valid))
        else $error("wrong handshake state after reset");

    // held head does not change under back-pressure
    a_uop_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (issue_valid && !issue_ready && !redirect) |=> $stable(issue_uop))
        else $error("issue_uop changed while waiting for issue_ready");

endmodule

bind decode_frontend decode_frontend_assert u_decode_frontend_assert (.*);

//--- tests/tb_decode_frontend.sv
//####################################################################
// decode front end testbench
// directed tests for decode, packing, back-pressure, hazards, flush
//####################################################################
`timescale 1ns/1ps

module tb_decode_frontend;

    localparam int TIMEOUT = 200; // cycles per wait

    logic                         CLK;
    logic                         nRST;
    logic                         fetch_valid;
    uop_types_pkg::fetch_bundle_t fetch_bundle;
    logic                         fetch_ready;
    logic                         redirect;
    logic                         issue_ready;
    logic                         issue_valid;
    uop_types_pkg::uop_t          issue_uop;
    uop_types_pkg::wb_t           wb;
    uop_types_pkg::uop_t          exp_q[$]; // expected issue order
    uop_types_pkg::uop_t          rx_q[$];  // issued uops
    int                           errors;
    int                           checks;

    decode_frontend #(.QUEUE_LEN(8), .DISPATCH_SIZE(2)) u_decode_frontend (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (nRST && issue_valid && issue_ready) rx_q.push_back(issue_uop); // issue monitor
    end

    // expected uop straight from the isa rules
    function automatic uop_types_pkg::uop_t ref_decode(logic [31:0] w, logic [31:0] pc);
        uop_types_pkg::uop_t u;
        logic                alt;
        u        = '0;
        u.valid  = 1'b1;
        u.pc     = pc;
        u.alu_op = uop_types_pkg::ADD;
        alt      = (w[31:25] == 7'h20);
        case (w[6:0])
            7'b0110111, 7'b0010111: begin // lui, auipc
                u.rd_we   = 1'b1;
                u.use_imm = 1'b1;
                u.imm     = {w[31:12], 12'h0};
            end
            7'b1101111: begin // jal
                u.rd_we   = 1'b1;
                u.use_imm = 1'b1;
                u.is_jump = 1'b1;
                u.imm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100011: begin // branch
                u.alu_op    = uop_types_pkg::SUB;
                u.is_branch = 1'b1;
                u.rs1       = w[19:15];
                u.rs2       = w[24:20];
                u.imm       = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0000011, 7'b1100111: begin // load, jalr
                u.rd_we   = 1'b1;
                u.use_imm = 1'b1;
                u.rs1     = w[19:15];
                u.imm     = {{20{w[31]}}, w[31:20]};
                u.is_load = (w[6:0] == 7'b0000011);
                u.is_jump = (w[6:0] == 7'b1100111);
            end
            7'b0100011: begin // store
                u.use_imm  = 1'b1;
                u.is_store = 1'b1;
                u.rs1      = w[19:15];
                u.rs2      = w[24:20];
                u.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b0010011, 7'b0110011: begin
                u.rd_we   = 1'b1;
                u.rs1     = w[19:15];
                u.use_imm = (w[6:0] == 7'b0010011);
                if (u.use_imm) u.imm = {{20{w[31]}}, w[31:20]};
                else u.rs2 = w[24:20];
                case (w[14:12])
                    3'd0: u.alu_op = (alt && !u.use_imm) ? uop_types_pkg::SUB : uop_types_pkg::ADD;
                    3'd1: u.alu_op = uop_types_pkg::SLL;
                    3'd2: u.alu_op = uop_types_pkg::SLT;
                    3'd3: u.alu_op = uop_types_pkg::SLTU;
                    3'd4: u.alu_op = uop_types_pkg::XOR;
                    3'd5: u.alu_op = alt ? uop_types_pkg::SRA : uop_types_pkg::SRL;
                    3'd6: u.alu_op = uop_types_pkg::OR;
                    default: u.alu_op = uop_types_pkg::AND;
                endcase
            end
            default: u.illegal = 1'b1; // unknown opcode
        endcase
        if (u.rd_we) u.rd = w[11:7];
        return u;
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [4:0] rnd_src(); // x16..x31 never written here
        return 5'(16 + $urandom_range(15));
    endfunction

    task automatic check_uop(string name, uop_types_pkg::uop_t got, uop_types_pkg::uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic give_up(string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    // starts 1 ns after an edge and ends 1 ns after the accepting edge
    task automatic send_bundle(logic [31:0] pc, logic [1:0] lv, logic [31:0] w0, logic [31:0] w1);
        int n;
        n = 0;
        fetch_valid = 1'b1;
        fetch_bundle = '{pc: pc, lane_valid: lv, instr: {w1, w0}};
        #1;
        while (!fetch_ready) begin
            @(posedge CLK);
            #2;
            n++;
            if (n > TIMEOUT) give_up("fetch_ready");
        end
        @(posedge CLK);
        #1 fetch_valid = 1'b0;
        if (lv[0]) exp_q.push_back(ref_decode(w0, pc));
        if (lv[1]) exp_q.push_back(ref_decode(w1, pc + 4));
    endtask

    task automatic writeback(logic [4:0] rd);
        wb = '{valid: 1'b1, rd: rd};
        @(posedge CLK);
        #1 wb = '0;
    endtask

    task automatic clear_busy();
        for (int r = 1; r < 32; r++) writeback(5'(r));
    endtask

    // waits for every expected issue and compares in order
    task automatic drain(string name);
        int n;
        n = 0;
        while (rx_q.size() < exp_q.size()) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > TIMEOUT) give_up({name, " issues"});
        end
        repeat (4) @(posedge CLK); // catch duplicates
        #1;
        check_count({name, " issue count"}, rx_q.size(), exp_q.size());
        while (rx_q.size() > 0 && exp_q.size() > 0) begin
            check_uop({name, " issue_uop"}, rx_q.pop_front(), exp_q.pop_front());
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic reset_state();
        check_bit("fetch_ready", fetch_ready, 1'b1);
        check_bit("issue_valid", issue_valid, 1'b0);
        repeat (5) @(posedge CLK);
        #1 check_count("idle issues", rx_q.size(), 0);
    endtask

    task automatic decode_classes();
        logic [31:0] words[8];
        words[0] = enc_r(7'h20, rnd_src(), rnd_src(), 3'd0, 5'd1);            // sub
        words[1] = enc_i(12'(32'h400 | 5'd3), rnd_src(), 3'd5, 5'd2, 7'b0010011); // srai
        words[2] = enc_i(12'($urandom), rnd_src(), 3'd2, 5'd3, 7'b0000011);   // lw
        words[3] = {7'($urandom), rnd_src(), rnd_src(), 3'd2, 5'($urandom), 7'b0100011};
        words[4] = {7'($urandom), rnd_src(), rnd_src(), 3'd1, 5'($urandom), 7'b1100011};
        words[5] = {20'($urandom), 5'd4, 7'b1101111};                         // jal
        words[6] = {20'($urandom), 5'd5, 7'b0110111};                         // lui
        words[7] = 32'hdead_beff;                                             // bad opcode
        for (int i = 0; i < 8; i++) send_bundle(32'h1000 + 64 * i, 2'b01, words[i], 32'h0);
        drain("decode");
        clear_busy();
    endtask

    task automatic lane_packing();
        send_bundle(32'h2000, 2'b11, enc_i(12'($urandom), rnd_src(), 3'd0, 5'd1, 7'b0010011),
                    enc_r(7'h00, rnd_src(), rnd_src(), 3'd7, 5'd2));
        send_bundle(32'h2100, 2'b10, 32'hffff_ffff,
                    enc_r(7'h00, rnd_src(), rnd_src(), 3'd6, 5'd3)); // lane 1 only
        send_bundle(32'h2200, 2'b11, enc_i(12'($urandom), rnd_src(), 3'd4, 5'd4, 7'b0010011),
                    enc_i(12'($urandom), rnd_src(), 3'd3, 5'd5, 7'b0010011));
        drain("packing");
        clear_busy();
    endtask

    task automatic backpressure();
        issue_ready = 1'b0;
        for (int b = 0; b < 4; b++) begin
            send_bundle(32'h3000 + 8 * b, 2'b11,
                        enc_i(12'($urandom), rnd_src(), 3'd0, 5'(2 * b + 1), 7'b0010011),
                        enc_i(12'($urandom), rnd_src(), 3'd6, 5'(2 * b + 2), 7'b0010011));
        end
        fetch_valid = 1'b1; // queue full so ninth and tenth uops do not fit
        #1 check_bit("fetch_ready", fetch_ready, 1'b0);
        @(posedge CLK);
        #1 fetch_valid = 1'b0;
        issue_ready = 1'b1;
        drain("backpressure");
        clear_busy();
    endtask

    task automatic raw_hazard();
        int n;
        n = 0;
        send_bundle(32'h4000, 2'b11, enc_i(12'($urandom), 5'd0, 3'd0, 5'd5, 7'b0010011),
                    enc_r(7'h00, 5'd0, 5'd5, 3'd0, 5'd6)); // reads x5
        while (rx_q.size() < 1) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > TIMEOUT) give_up("x5 writer");
        end
        repeat (3) @(posedge CLK);
        #1 check_count("issues before wb", rx_q.size(), 1);
        check_bit("issue_valid", issue_valid, 1'b0);
        writeback(5'd5);
        drain("hazard");
        clear_busy();
        send_bundle(32'h4100, 2'b11, enc_i(12'($urandom), 5'd0, 3'd0, 5'd0, 7'b0010011),
                    enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0)); // x0 only
        repeat (2) @(posedge CLK);
        #1 check_count("x0 issues", rx_q.size(), 2);
        drain("x0");
    endtask

    task automatic redirect_flush();
        issue_ready = 1'b0;
        send_bundle(32'h5000, 2'b11, enc_i(12'h1, rnd_src(), 3'd0, 5'd1, 7'b0010011),
                    enc_i(12'h2, rnd_src(), 3'd0, 5'd2, 7'b0010011));
        send_bundle(32'h5008, 2'b01, enc_i(12'h3, rnd_src(), 3'd0, 5'd3, 7'b0010011), 32'h0);
        exp_q.delete(); // these get flushed
        redirect = 1'b1;
        @(posedge CLK);
        #1 redirect = 1'b0;
        issue_ready = 1'b1;
        repeat (4) @(posedge CLK);
        #1 check_count("flushed issues", rx_q.size(), 0);
        send_bundle(32'h6000, 2'b11, enc_i(12'h4, rnd_src(), 3'd0, 5'd4, 7'b0010011),
                    enc_r(7'h20, rnd_src(), rnd_src(), 3'd0, 5'd7));
        drain("after flush");
    endtask

    initial begin
        void'($urandom(32'h9364));
        errors = 0;
        checks = 0;
        nRST = 1'b0;
        fetch_valid = 1'b0;
        fetch_bundle = '0;
        redirect = 1'b0;
        issue_ready = 1'b1;
        wb = '0;
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
        reset_state();
        decode_classes();
        lane_packing();
        backpressure();
        raw_hazard();
        redirect_flush();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- decode_frontend.f
common/rv32i_isa_pkg.sv
common/uop_types_pkg.sv
decode_queue/decode_queue.sv
decoder/uop_decoder.sv
decoder/fetch_bundle_decode.sv
design/issue_scoreboard.sv
design/decode_frontend.sv
tests/decode_frontend_assert.sv
tests/tb_decode_frontend.sv

//--- Bender.yml
package:
  name: decode_frontend

sources:
  - common/rv32i_isa_pkg.sv
  - common/uop_types_pkg.sv
  - decode_queue/decode_queue.sv
  - decoder/uop_decoder.sv
  - decoder/fetch_bundle_decode.sv
  - design/issue_scoreboard.sv
  - design/decode_frontend.sv
  - target: test
    files:
      - tests/decode_frontend_assert.sv
      - tests/tb_decode_frontend.sv
